/* bench/tb_mem_subsys.sv */
`default_nettype none

module tb_mem_subsys;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period = 40;
   localparam int fill_words = 16;
   localparam int total_ops  = 2 * fill_words + 150 + 150 + 200 + 200;

   logic                                   clk = 1'b0;
   logic                                   resetn;
   logic [sram_bridge_pkg::addr_width-1:0] awaddr;
   logic [sram_bridge_pkg::prot_width-1:0] awprot;
   logic                                   awvalid;
   logic                                   awready;
   logic [sram_bridge_pkg::data_width-1:0] wdata;
   logic [sram_bridge_pkg::strb_width-1:0] wstrb;
   logic                                   wvalid;
   logic                                   wready;
   logic [sram_bridge_pkg::resp_width-1:0] bresp;
   logic                                   bvalid;
   logic                                   bready;
   logic [sram_bridge_pkg::addr_width-1:0] araddr;
   logic [sram_bridge_pkg::prot_width-1:0] arprot;
   logic                                   arvalid;
   logic                                   arready;
   logic [sram_bridge_pkg::data_width-1:0] rdata;
   logic [sram_bridge_pkg::resp_width-1:0] rresp;
   logic                                   rvalid;
   logic                                   rready;

   logic [31:0] seed = 32'h7727_d4d1;
   logic [31:0] model_mem [sram_bridge_pkg::mem_words];
   logic        exp_write [$];   // Expected responses in handshake order.
   logic [1:0]  exp_resp [$];
   logic [31:0] exp_data [$];
   int          err_count = 0;
   int          resp_count = 0;
   int          wr_hs_count = 0;
   int          rd_hs_count = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   logic        quiet = 1'b0;    // No ready or valid may be high.
   logic        r_stalled = 1'b0;
   logic        b_stalled = 1'b0;
   logic [31:0] r_data_q;
   logic [1:0]  r_resp_q;
   logic [1:0]  b_resp_q;

   always #(clk_period / 2) clk = ~clk;

   mem_subsys_top i_dut
   (
      .clk     (clk),
      .resetn  (resetn),
      .awaddr  (awaddr),
      .awprot  (awprot),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arprot  (arprot),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Sixteen words spread over the window. Out-of-window addresses alias them.
   function automatic logic [31:0] pool_addr(input logic [3:0] slot, input int err_pct);
      logic [19:0] high;
      high = '0;
      if (int'(lcg_next() % 100) < err_pct)
         high = 20'(lcg_next()) | 20'h1;
      return {high, slot, 6'd5, 2'b00};
   endfunction

   task automatic check_value(input string sig, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("Mismatch at %0d ns: %s expected %h, actual %h", $time, sig, expected, actual);
         err_count++;
      end
   endtask

   task automatic match_response(input logic is_write, input logic [1:0] resp,
                                 input logic [31:0] data);
      assert (exp_write.size() != 0)
      else
      begin
         $display("A response arrived at %0d ns with no request outstanding", $time);
         err_count++;
      end
      if (exp_write.size() != 0)
      begin
         check_value("response kind (1 = B)", 32'(exp_write[0]), 32'(is_write));
         check_value(is_write ? "bresp" : "rresp", 32'(exp_resp[0]), 32'(resp));
         if (!is_write)
            check_value("rdata", exp_data[0], data);
         void'(exp_write.pop_front());
         void'(exp_resp.pop_front());
         void'(exp_data.pop_front());
         resp_count++;
      end
   endtask

   // Observes the ports on each rising edge and keeps the model in handshake order.
   always @(posedge clk)
   begin
      logic hs_err;
      if (quiet)
      begin
         check_value("awready", 0, 32'(awready));
         check_value("wready", 0, 32'(wready));
         check_value("arready", 0, 32'(arready));
         check_value("rvalid", 0, 32'(rvalid));
         check_value("bvalid", 0, 32'(bvalid));
      end
      if (!resetn)
      begin
         if (r_stalled)
         begin
            check_value("rvalid", 1, 32'(rvalid));
            check_value("rdata", r_data_q, rdata);
            check_value("rresp", 32'(r_resp_q), 32'(rresp));
         end
         if (b_stalled)
         begin
            check_value("bvalid", 1, 32'(bvalid));
            check_value("bresp", 32'(b_resp_q), 32'(bresp));
         end
         if (awvalid && awready)
         begin
            check_value("wready", 1, 32'(wready));
            hs_err = awaddr >= 32'(4 * sram_bridge_pkg::mem_words);   // Past the 4 KiB window.
            if (!hs_err)
               for (int b = 0; b < 4; b++)
                  if (wstrb[b])
                     model_mem[awaddr[11:2]][8*b +: 8] = wdata[8*b +: 8];
            exp_write.push_back(1'b1);
            exp_resp.push_back(hs_err ? sram_bridge_pkg::resp_slverr : sram_bridge_pkg::resp_okay);
            exp_data.push_back('0);
            wr_hs_count++;
         end
         if (arvalid && arready)
         begin
            hs_err = araddr >= 32'(4 * sram_bridge_pkg::mem_words);
            exp_write.push_back(1'b0);
            exp_resp.push_back(hs_err ? sram_bridge_pkg::resp_slverr : sram_bridge_pkg::resp_okay);
            exp_data.push_back(hs_err ? 32'h0 : model_mem[araddr[11:2]]);
            rd_hs_count++;
         end
         if (rvalid && rready)
            match_response(1'b0, rresp, rdata);
         if (bvalid && bready)
            match_response(1'b1, bresp, 32'h0);
         r_stalled = rvalid && !rready;
         b_stalled = bvalid && !bready;
         r_data_q  = rdata;
         r_resp_q  = rresp;
         b_resp_q  = bresp;
      end
   end

   task automatic offer_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      awaddr  = addr;
      awprot  = 3'(lcg_next());   // Ignored by the DUT.
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
   endtask

   task automatic offer_read(input logic [31:0] addr);
      araddr  = addr;
      arprot  = 3'(lcg_next());
      arvalid = 1'b1;
   endtask

   task automatic report_test(input string name, input bit ok);
      if (ok)
         tests_passed++;
      else
         tests_failed++;
      $display("%s: %s (%0d responses so far)", name, ok ? "passed" : "failed", resp_count);
   endtask

   task automatic run_test(input string name, input int n_ops, input bit fill_then_read,
                           input bit full_strb, input int err_pct, input int stall_pct);
      int          issued;
      int          wr_seen;
      int          rd_seen;
      int          errors_before;
      int          resp_before;
      logic [31:0] r;
      issued        = 0;
      wr_seen       = wr_hs_count;
      rd_seen       = rd_hs_count;
      errors_before = err_count;
      resp_before   = resp_count;
      while (issued < n_ops || awvalid || arvalid || exp_write.size() != 0)
      begin
         @(negedge clk);
         if (wr_hs_count != wr_seen)
         begin
            wr_seen = wr_hs_count;
            awvalid = 1'b0;
            wvalid  = 1'b0;
         end
         if (rd_hs_count != rd_seen)
         begin
            rd_seen = rd_hs_count;
            arvalid = 1'b0;
         end
         rready = int'(lcg_next() % 100) >= stall_pct;
         bready = int'(lcg_next() % 100) >= stall_pct;
         if (issued < n_ops && fill_then_read)
         begin
            if (!awvalid && !arvalid && exp_write.size() == 0)
            begin
               if (issued < fill_words)
                  offer_write(pool_addr(4'(issued), 0), lcg_next(), 4'hf);
               else
                  offer_read(pool_addr(4'(issued - fill_words), 0));
               issued++;
            end
         end
         else if (issued < n_ops)
         begin
            r = lcg_next();
            // Bit 9 offers a read and a write to the same word together.
            if ((r[0] || r[9]) && !awvalid)
            begin
               offer_write(pool_addr(r[4:1], err_pct), lcg_next(), full_strb ? 4'hf : r[8:5]);
               issued++;
            end
            if ((!r[0] || r[9]) && !arvalid && issued < n_ops)
            begin
               offer_read(pool_addr(r[4:1], err_pct));
               issued++;
            end
         end
      end
      report_test(name, err_count == errors_before && resp_count - resp_before == n_ops);
   endtask

   initial
   begin
      resetn  = 1'b1;
      awaddr  = '0;
      awprot  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      araddr  = '0;
      arprot  = '0;
      arvalid = 1'b0;
      rready  = 1'b1;
      @(negedge clk);
      quiet = 1'b1;
      offer_write(pool_addr(4'd0, 0), lcg_next(), 4'hf);   // Must not be taken in reset.
      offer_read(pool_addr(4'd1, 0));
      repeat (2) @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      @(negedge clk);
      resetn = 1'b0;
      repeat (4) @(negedge clk);
      quiet = 1'b0;
      report_test("reset state", err_count == 0 && resp_count == 0);

      run_test("write then read back", 2 * fill_words, 1'b1, 1'b1, 0, 0);
      run_test("byte strobes", 150, 1'b0, 1'b0, 0, 0);
      run_test("address errors", 150, 1'b0, 1'b1, 50, 0);
      run_test("mixed ordering", 200, 1'b0, 1'b0, 10, 0);
      run_test("back-pressure", 200, 1'b0, 1'b0, 10, 50);

      $display("Tests passed: %0d, failed: %0d, check errors: %0d",
               tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   initial
   begin
      #(total_ops * 40 * clk_period);
      $display("The run hung: the tests did not finish within %0d cycles", total_ops * 40);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
rtl/sram_bridge_pkg.sv
rtl/bridge_if.sv
rtl/axil_req_stage.sv
rtl/sram_access_stage.sv
rtl/sram_array.sv
rtl/axil_resp_stage.sv
rtl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

/* rtl/axil_req_stage.sv */
`default_nettype none

module axil_req_stage
(
   input  wire                                    clk,
   input  wire                                    resetn,
   input  wire [sram_bridge_pkg::addr_width-1:0]  awaddr,
   input  wire                                    awvalid,
   output logic                                   awready,
   input  wire [sram_bridge_pkg::data_width-1:0]  wdata,
   input  wire [sram_bridge_pkg::strb_width-1:0]  wstrb,
   input  wire                                    wvalid,
   output logic                                   wready,
   input  wire [sram_bridge_pkg::addr_width-1:0]  araddr,
   input  wire                                    arvalid,
   output logic                                   arready,
   mem_req_if.master                              req
);

   logic                                   can_accept;
   logic                                   wr_offer;
   logic                                   wr_grant;
   logic                                   rd_grant;
   logic                                   accept;
   logic                                   last_write;
   logic [sram_bridge_pkg::addr_width-1:0] addr_sel;

   assign can_accept = !resetn && (!req.valid || req.ready);   // Out of reset and empty or being emptied.
   assign wr_offer   = awvalid && wvalid;         // A write needs both AW and W.

   // Round robin. The kind not granted last wins a tie.
   assign wr_grant = wr_offer && (!arvalid || !last_write);
   assign rd_grant = arvalid && (!wr_offer || last_write);

   assign awready = can_accept && wr_grant;
   assign wready  = can_accept && wr_grant;
   assign arready = can_accept && rd_grant;
   assign accept  = awready || arready;

   assign addr_sel = wr_grant ? awaddr : araddr;

   always_ff @(posedge clk or posedge resetn)
   begin
      if (resetn)
      begin
         req.valid  <= 1'b0;
         last_write <= 1'b0;   // Write wins first.
      end
      else
      begin
         if (can_accept)
            req.valid <= accept;
         if (accept)
            last_write <= wr_grant;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         req.write <= wr_grant;
         req.index <= addr_sel[sram_bridge_pkg::mem_addr_bits-1:2];
         req.err   <= |addr_sel[sram_bridge_pkg::addr_width-1:sram_bridge_pkg::mem_addr_bits];
         req.wdata <= wdata;
         req.wstrb <= wstrb;
      end
   end

   // The master holds a valid until its handshake.
   assert property (@(posedge clk) disable iff (resetn)
      awvalid && !awready |=> awvalid);

   assert property (@(posedge clk) disable iff (resetn)
      arvalid && !arready |=> arvalid);

   // A stalled request holds until the access stage takes it.
   assert property (@(posedge clk) disable iff (resetn)
      req.valid && !req.ready |=> req.valid &&
         $stable({req.write, req.index, req.err, req.wdata, req.wstrb}));

endmodule

`default_nettype wire

/* rtl/axil_resp_stage.sv */
`default_nettype none

module axil_resp_stage
(
   input  wire                                          clk,
   input  wire                                          resetn,
   mem_rsp_if.slave                                     rsp,
   output logic [sram_bridge_pkg::data_width-1:0]       rdata,
   output logic [sram_bridge_pkg::resp_width-1:0]       rresp,
   output logic                                         rvalid,
   input  wire                                          rready,
   output logic [sram_bridge_pkg::resp_width-1:0]       bresp,
   output logic                                         bvalid,
   input  wire                                          bready
);

   logic                                   held;
   logic                                   held_write;
   logic                                   held_err;
   logic [sram_bridge_pkg::data_width-1:0] held_data;
   logic [sram_bridge_pkg::resp_width-1:0] code;

   assign rvalid = held && !held_write;
   assign bvalid = held && held_write;

   assign rsp.ready = !held || (rvalid && rready) || (bvalid && bready);

   assign code  = held_err ? sram_bridge_pkg::resp_slverr : sram_bridge_pkg::resp_okay;
   assign rresp = code;
   assign bresp = code;
   assign rdata = held_data;

   always_ff @(posedge clk or posedge resetn)
   begin
      if (resetn)
         held <= 1'b0;
      else if (rsp.ready)
         held <= rsp.valid;
   end

   always_ff @(posedge clk)
   begin
      if (rsp.valid && rsp.ready)
      begin
         held_write <= rsp.write;
         held_err   <= rsp.err;
         held_data  <= rsp.err ? '0 : rsp.rdata;   // Zero data on error.
      end
   end

   assert property (@(posedge clk) disable iff (resetn)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

   assert property (@(posedge clk) disable iff (resetn)
      bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

/* rtl/bridge_if.sv */
`default_nettype none

// Request stage to access stage.
interface mem_req_if;

   logic                                       valid;
   logic                                       ready;
   logic                                       write;
   logic [sram_bridge_pkg::mem_index_bits-1:0] index;
   logic [sram_bridge_pkg::data_width-1:0]     wdata;
   logic [sram_bridge_pkg::strb_width-1:0]     wstrb;
   logic                                       err;   // Address outside the window.

   modport master
   (
      output valid, write, index, wdata, wstrb, err,
      input  ready
   );

   modport slave
   (
      input  valid, write, index, wdata, wstrb, err,
      output ready
   );

endinterface

// Access stage to response stage.
interface mem_rsp_if;

   logic                                   valid;
   logic                                   ready;
   logic                                   write;
   logic [sram_bridge_pkg::data_width-1:0] rdata;
   logic                                   err;

   modport master
   (
      output valid, write, rdata, err,
      input  ready
   );

   modport slave
   (
      input  valid, write, rdata, err,
      output ready
   );

endinterface

`default_nettype wire

/* rtl/mem_subsys_top.sv */
`default_nettype none

module mem_subsys_top
(
   input  wire                                     clk,
   input  wire                                     resetn,

   input  wire [sram_bridge_pkg::addr_width-1:0]   awaddr,
   input  wire [sram_bridge_pkg::prot_width-1:0]   awprot,   // Protection is not checked.
   input  wire                                     awvalid,
   output logic                                    awready,

   input  wire [sram_bridge_pkg::data_width-1:0]   wdata,
   input  wire [sram_bridge_pkg::strb_width-1:0]   wstrb,
   input  wire                                     wvalid,
   output logic                                    wready,

   output logic [sram_bridge_pkg::resp_width-1:0]  bresp,
   output logic                                    bvalid,
   input  wire                                     bready,

   input  wire [sram_bridge_pkg::addr_width-1:0]   araddr,
   input  wire [sram_bridge_pkg::prot_width-1:0]   arprot,
   input  wire                                     arvalid,
   output logic                                    arready,

   output logic [sram_bridge_pkg::data_width-1:0]  rdata,
   output logic [sram_bridge_pkg::resp_width-1:0]  rresp,
   output logic                                    rvalid,
   input  wire                                     rready
);

   mem_req_if req_bus ();
   mem_rsp_if rsp_bus ();

   axil_req_stage i_req
   (
      .clk     (clk),
      .resetn  (resetn),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .req     (req_bus.master)
   );

   sram_access_stage i_access
   (
      .clk    (clk),
      .resetn (resetn),
      .req    (req_bus.slave),
      .rsp    (rsp_bus.master)
   );

   axil_resp_stage i_resp
   (
      .clk    (clk),
      .resetn (resetn),
      .rsp    (rsp_bus.slave),
      .rdata  (rdata),
      .rresp  (rresp),
      .rvalid (rvalid),
      .rready (rready),
      .bresp  (bresp),
      .bvalid (bvalid),
      .bready (bready)
   );

endmodule

`default_nettype wire

/* rtl/sram_access_stage.sv */
`default_nettype none

module sram_access_stage
(
   input  wire       clk,
   input  wire       resetn,
   mem_req_if.slave  req,
   mem_rsp_if.master rsp
);

   logic                                   take;
   logic                                   ren;
   logic [sram_bridge_pkg::strb_width-1:0] wen;
   sram_bridge_pkg::sram_word_u            wword;
   sram_bridge_pkg::sram_word_u            rword;

   assign req.ready = !rsp.valid || rsp.ready;
   assign take      = req.valid && req.ready;

   // Errored requests never touch the memory.
   assign ren  = take && !req.write && !req.err;
   assign wen  = (take && req.write && !req.err) ? req.wstrb : '0;

   assign wword.word = req.wdata;

   // The SRAM output only moves on a new read, so it holds while rsp stalls.
   assign rsp.rdata = rword.word;

   sram_array i_sram
   (
      .clk    (clk),
      .ren    (ren),
      .rindex (req.index),
      .wen    (wen),
      .windex (req.index),
      .wword  (wword),
      .rword  (rword)
   );

   always_ff @(posedge clk or posedge resetn)
   begin
      if (resetn)
         rsp.valid <= 1'b0;
      else if (req.ready)
         rsp.valid <= req.valid;
   end

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         rsp.write <= req.write;
         rsp.err   <= req.err;
      end
   end

   // A stalled response keeps its word until the response stage takes it.
   assert property (@(posedge clk) disable iff (resetn)
      rsp.valid && !rsp.ready |=> rsp.valid && $stable({rsp.write, rsp.err, rsp.rdata}));

endmodule

`default_nettype wire

/* rtl/sram_array.sv */
`default_nettype none

module sram_array
(
   input  wire                                         clk,
   input  wire                                         ren,
   input  wire [sram_bridge_pkg::mem_index_bits-1:0]   rindex,
   input  wire [sram_bridge_pkg::strb_width-1:0]       wen,     // One enable per byte lane.
   input  wire [sram_bridge_pkg::mem_index_bits-1:0]   windex,
   input  wire sram_bridge_pkg::sram_word_u            wword,
   output sram_bridge_pkg::sram_word_u                 rword
);

   sram_bridge_pkg::sram_word_u mem [sram_bridge_pkg::mem_words];

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < sram_bridge_pkg::strb_width; i++)
      begin
         if (wen[i])
            mem[windex].bytes[i] <= wword.bytes[i];
      end
      if (ren)
         rword.word <= mem[rindex].word;   // Valid the cycle after ren.
   end

endmodule

`default_nettype wire

/* rtl/sram_bridge_pkg.sv */
`default_nettype none

package sram_bridge_pkg;

   localparam int addr_width     = 32;
   localparam int data_width     = 32;
   localparam int strb_width     = data_width / 8;
   localparam int prot_width     = 3;
   localparam int resp_width     = 2;

   localparam int mem_index_bits = 10;
   localparam int mem_words      = 1 << mem_index_bits;
   localparam int mem_addr_bits  = mem_index_bits + 2;  // Byte address bits of the 4 KiB window.

   localparam logic [resp_width-1:0] resp_okay   = 2'b00;
   localparam logic [resp_width-1:0] resp_slverr = 2'b10;

   // One SRAM word, seen whole or as byte lanes.
   typedef union packed
   {
      logic [data_width-1:0]      word;
      logic [strb_width-1:0][7:0] bytes;
   } sram_word_u;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f compile.f --top-module tb_mem_subsys -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

output=$(./obj_dir/sim_tb)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
